// File: src/tile_mem_macros.svh
/* Tile memory macros: word and address widths, memory depths,
   region codes, response select codes and response FIFO depth */
`ifndef TILE_MEM_MACROS_SVH
`define TILE_MEM_MACROS_SVH

// ====================
// Word and address layout
// ====================
`define WORD_W          32          // Data word width
`define WORD_LSB        2           // Byte offset bits below the word address
`define REGION_W        8           // Region field on top of the fabric address
`define TILE_ID_W       8           // Tile id, same width as region
`define OFFSET_W        24          // Byte offset inside a tile

// ====================
// Memory depths (word address bits)
// ====================
`define IMEM_ADDR_W     13          // 32 KB instruction memory
`define DMEM_ADDR_W     14          // 64 KB data memory

// Region codes seen in address[31:24]
`define IMEM_REGION     8'h01
`define DMEM_REGION     8'h02

// Read response source select
`define RD_SEL_NONE     2'd0        // Unmapped, answers zero
`define RD_SEL_IMEM     2'd1
`define RD_SEL_DMEM     2'd2

`define RSP_FIFO_DEPTH  4           // Read response queue entries

`endif

// File: src/tile_mem_pkg.sv
/* Tile memory package: fabric opcode, tile id, fabric address union
   and the fabric transaction struct */
`default_nettype none

`include "tile_mem_macros.svh"

package tile_mem_pkg;

    // ====================
    // Fabric opcodes
    // ====================
    typedef enum logic [1:0] {
        WR     = 2'b00,     // Full word write
        RD     = 2'b01,     // Read request
        RD_RSP = 2'b10      // Read response back to requestor
    } t_opcode;

    typedef logic [`TILE_ID_W-1:0] t_tile_id;

    // Request side view of the address
    typedef struct packed {
        logic [`REGION_W-1:0] region;   // Selects IMEM / DMEM
        logic [`OFFSET_W-1:0] offset;   // Byte offset
    } t_mem_view;

    // Response side view of the address
    typedef struct packed {
        t_tile_id             tile;     // Target tile of the response
        logic [`OFFSET_W-1:0] offset;   // Same offset as the request
    } t_rsp_view;

    // ====================
    // One address word, two decodings
    // ====================
    // Decode reads mem, result writes rsp
    typedef union packed {
        t_mem_view mem;
        t_rsp_view rsp;
    } t_fabric_addr;

    // Fabric transaction, 74 bits
    typedef struct packed {
        t_fabric_addr       address;
        logic [`WORD_W-1:0] data;
        t_opcode            opcode;
        t_tile_id           requestor_id;   // Who asked, or who answers
    } t_tile_trans;

endpackage

`default_nettype wire

// File: src/mem_req_if.sv
/* Decoded fabric request from decode to the memory array */
`default_nettype none
`timescale 1ns/1ps

`include "tile_mem_macros.svh"

interface mem_req_if;
    import tile_mem_pkg::*;

    // ====================
    // Request signals
    // ====================
    logic                    imem_wr;      // Write strobe to instruction memory
    logic                    dmem_wr;      // Write strobe to data memory
    logic                    rd;           // Fabric read strobe
    logic [1:0]              rd_sel;       // IMEM / DMEM / none
    logic [`DMEM_ADDR_W-1:0] word_addr;    // Widest word address, IMEM uses low bits
    logic [`WORD_W-1:0]      wr_data;      // Full word, no byte enables
    t_fabric_addr            rsp_target;   // Where the read response goes

    // Decode side
    modport dec (
        output imem_wr,
        output dmem_wr,
        output rd,
        output rd_sel,
        output word_addr,
        output wr_data,
        output rsp_target
    );

    // Memory side
    modport exe (
        input imem_wr,
        input dmem_wr,
        input rd,
        input rd_sel,
        input word_addr,
        input wr_data,
        input rsp_target
    );

endinterface

`default_nettype wire

// File: src/fabric_req_decode.sv
/* Fabric request decode: region match, memory write strobes,
   read strobe with source select and the response target */
`default_nettype none
`timescale 1ns/1ps

`include "tile_mem_macros.svh"

module fabric_req_decode (
    input  logic                      in_valid,     // One cycle strobe
    input  tile_mem_pkg::t_tile_trans in_trans,
    mem_req_if.dec                    req
);
    import tile_mem_pkg::*;

    logic imem_hit;
    logic dmem_hit;
    logic is_wr;
    logic is_rd;

    // ====================
    // Region match
    // ====================
    // Exact code compare on the mem view
    assign imem_hit = (in_trans.address.mem.region == `IMEM_REGION);
    assign dmem_hit = (in_trans.address.mem.region == `DMEM_REGION);

    assign is_wr = in_valid && (in_trans.opcode == WR);
    assign is_rd = in_valid && (in_trans.opcode == RD);

    // ====================
    // Memory strobes
    // ====================
    assign req.imem_wr = is_wr && imem_hit;     // Unmapped writes dropped
    assign req.dmem_wr = is_wr && dmem_hit;
    assign req.rd      = is_rd;                 // Every read gets an answer

    always_comb begin
        if (imem_hit) begin
            req.rd_sel = `RD_SEL_IMEM;
        end else if (dmem_hit) begin
            req.rd_sel = `RD_SEL_DMEM;
        end else begin
            req.rd_sel = `RD_SEL_NONE;          // Zero data response
        end
    end

    // Word address, drop byte bits
    assign req.word_addr = in_trans.address.mem.offset[`DMEM_ADDR_W+`WORD_LSB-1:`WORD_LSB];
    assign req.wr_data   = in_trans.data;

    // ====================
    // Response target
    // ====================
    // Requestor id goes in the tile field, offset kept
    assign req.rsp_target.rsp.tile   = in_trans.requestor_id;
    assign req.rsp_target.rsp.offset = in_trans.address.mem.offset;

    // Only writes and reads are meant for a memory tile
    always_comb begin
        assert (!in_valid || (in_trans.opcode inside {WR, RD}))
            else $error("fabric_req_decode: opcode %h not WR or RD", in_trans.opcode);
    end

endmodule

`default_nettype wire

// File: src/dual_port_ram.sv
/* Behavioral two port RAM, byte enables on both ports,
   registered read of old data */
`default_nettype none
`timescale 1ns/1ps

`include "tile_mem_macros.svh"

module dual_port_ram #(
    parameter int ADDR_W = 13                   // Word address bits
) (
    input  logic                 clock,
    // Port A
    input  logic [ADDR_W-1:0]    addr_a,
    input  logic [`WORD_W-1:0]   wdata_a,
    input  logic                 we_a,
    input  logic [`WORD_W/8-1:0] be_a,
    output logic [`WORD_W-1:0]   q_a,
    // Port B
    input  logic [ADDR_W-1:0]    addr_b,
    input  logic [`WORD_W-1:0]   wdata_b,
    input  logic                 we_b,
    input  logic [`WORD_W/8-1:0] be_b,
    output logic [`WORD_W-1:0]   q_b
);

    logic [`WORD_W-1:0] ram [2**ADDR_W];    // Contents not reset

    // ====================
    // Write and read
    // ====================
    always_ff @(posedge clock) begin
        for (int i = 0; i < `WORD_W/8; i++) begin
            if (we_a && be_a[i]) begin
                ram[addr_a][8*i +: 8] <= wdata_a[8*i +: 8];
            end
            if (we_b && be_b[i]) begin
                ram[addr_b][8*i +: 8] <= wdata_b[8*i +: 8];   // B last on collision
            end
        end
        q_a <= ram[addr_a];                 // Read before write
        q_b <= ram[addr_b];
    end

    // Same word written by both ports is undefined
    a_no_wr_collision: assert property (@(posedge clock)
        !(we_a && we_b && (addr_a == addr_b)))
        else $error("dual_port_ram: write collision at word %h", addr_a);

endmodule

`default_nettype wire

// File: src/tile_mem_array.sv
/* Execute stage: instruction and data memories, core on port A,
   fabric on port B, read response data select */
`default_nettype none
`timescale 1ns/1ps

`include "tile_mem_macros.svh"

module tile_mem_array (
    input  logic                       clock,
    input  logic                       rst_n,
    // Core fetch
    input  logic [31:0]                pc,
    output logic [`WORD_W-1:0]         instruction,     // Word of pc, one cycle later
    // Core data
    input  logic [31:0]                dmem_address,
    input  logic [`WORD_W-1:0]         dmem_wr_data,
    input  logic [`WORD_W/8-1:0]       dmem_byte_en,
    input  logic                       dmem_wr_en,
    output logic [`WORD_W-1:0]         dmem_rd_data,
    // Fabric
    mem_req_if.exe                     req,
    output logic                       rsp_valid,       // Pulse
    output logic [`WORD_W-1:0]         rsp_data,
    output tile_mem_pkg::t_fabric_addr rsp_target
);
    import tile_mem_pkg::*;

    logic [`WORD_W-1:0] imem_q_b;
    logic [`WORD_W-1:0] dmem_q_b;
    logic               rd_q;
    logic [1:0]         rd_sel_q;
    t_fabric_addr       rsp_target_q;

    // ====================
    // Instruction memory
    // ====================
    dual_port_ram #(.ADDR_W(`IMEM_ADDR_W)) i_mem (
        .clock   (clock),
        .addr_a  (pc[`IMEM_ADDR_W+`WORD_LSB-1:`WORD_LSB]),    // Fetch only
        .wdata_a ('0),
        .we_a    (1'b0),
        .be_a    ('0),
        .q_a     (instruction),
        .addr_b  (req.word_addr[`IMEM_ADDR_W-1:0]),
        .wdata_b (req.wr_data),
        .we_b    (req.imem_wr),
        .be_b    ('1),                      // Fabric writes full words
        .q_b     (imem_q_b)
    );

    // ====================
    // Data memory
    // ====================
    dual_port_ram #(.ADDR_W(`DMEM_ADDR_W)) d_mem (
        .clock   (clock),
        .addr_a  (dmem_address[`DMEM_ADDR_W+`WORD_LSB-1:`WORD_LSB]),
        .wdata_a (dmem_wr_data),
        .we_a    (dmem_wr_en),
        .be_a    (dmem_byte_en),
        .q_a     (dmem_rd_data),
        .addr_b  (req.word_addr),
        .wdata_b (req.wr_data),
        .we_b    (req.dmem_wr),
        .be_b    ('1),
        .q_b     (dmem_q_b)
    );

    // Align read control with RAM output
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_q     <= 1'b0;
            rd_sel_q <= `RD_SEL_NONE;
        end else begin
            rd_q     <= req.rd;
            rd_sel_q <= req.rd_sel;
        end
    end

    always_ff @(posedge clock) begin
        rsp_target_q <= req.rsp_target;
    end

    assign rsp_valid  = rd_q;
    assign rsp_target = rsp_target_q;
    assign rsp_data   = (rd_sel_q == `RD_SEL_IMEM) ? imem_q_b :
                        (rd_sel_q == `RD_SEL_DMEM) ? dmem_q_b :
                                                     '0;       // Unmapped region

endmodule

`default_nettype wire

// File: src/rd_rsp_queue.sv
/* Result stage: builds read response transactions and queues them
   in a small circular FIFO drained when out_stall is low */
`default_nettype none
`timescale 1ns/1ps

`include "tile_mem_macros.svh"

module rd_rsp_queue (
    input  logic                       clock,
    input  logic                       rst_n,
    input  tile_mem_pkg::t_tile_id     local_tile_id,
    // From execute
    input  logic                       rsp_valid,
    input  logic [`WORD_W-1:0]         rsp_data,
    input  tile_mem_pkg::t_fabric_addr rsp_target,
    // To fabric
    input  logic                       out_stall,   // Level, holds the queue
    output logic                       out_valid,   // One pulse per response
    output tile_mem_pkg::t_tile_trans  out_trans,
    output logic                       rsp_full
);
    import tile_mem_pkg::*;

    localparam int PTR_W = $clog2(`RSP_FIFO_DEPTH);

    t_tile_trans      rsp_trans;
    t_tile_trans      fifo_mem [`RSP_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                    // 0 .. DEPTH
    logic             empty;
    logic             push;
    logic             pop;

    // ====================
    // Response format
    // ====================
    always_comb begin
        rsp_trans.address      = rsp_target;    // Tile field already holds requestor
        rsp_trans.data         = rsp_data;
        rsp_trans.opcode       = RD_RSP;
        rsp_trans.requestor_id = local_tile_id; // Answering tile
    end

    // ====================
    // FIFO control
    // ====================
    assign empty    = (count == '0);
    assign rsp_full = (count == (PTR_W+1)'(`RSP_FIFO_DEPTH));
    assign push     = rsp_valid;
    assign pop      = !empty && !out_stall;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`RSP_FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`RSP_FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or push with pop
            endcase
        end
    end

    // Storage, payload only
    always_ff @(posedge clock) begin
        if (push) begin
            fifo_mem[wr_ptr] <= rsp_trans;
        end
    end

    // ====================
    // Output
    // ====================
    assign out_valid = pop;                     // Head leaves this cycle
    assign out_trans = fifo_mem[rd_ptr];

    // Fabric must respect rsp_full, a read two cycles back lands here
    a_no_push_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        push |-> !rsp_full)
        else $error("rd_rsp_queue: push into full FIFO, count %h", count);

endmodule

`default_nettype wire

// File: src/tile_mem_top.sv
/* Tile memory top: decode, memory array and response queue
   behind plain core and fabric ports */
`default_nettype none
`timescale 1ns/1ps

`include "tile_mem_macros.svh"

module tile_mem_top (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`TILE_ID_W-1:0]  local_tile_id,
    // Core
    input  logic [31:0]            pc,
    output logic [`WORD_W-1:0]     instruction,
    input  logic [31:0]            dmem_address,
    input  logic [`WORD_W-1:0]     dmem_wr_data,
    input  logic [`WORD_W/8-1:0]   dmem_byte_en,
    input  logic                   dmem_wr_en,
    output logic [`WORD_W-1:0]     dmem_rd_data,
    // Fabric in
    input  logic                   in_valid,
    input  logic [31:0]            in_address,
    input  logic [`WORD_W-1:0]     in_data,
    input  logic [1:0]             in_opcode,
    input  logic [`TILE_ID_W-1:0]  in_requestor_id,
    // Fabric out
    output logic                   out_valid,
    output logic [31:0]            out_address,
    output logic [`WORD_W-1:0]     out_data,
    output logic [1:0]             out_opcode,
    output logic [`TILE_ID_W-1:0]  out_requestor_id,
    input  logic                   out_stall,
    output logic                   rsp_full
);
    import tile_mem_pkg::*;

    t_tile_trans        in_trans;
    t_tile_trans        out_trans;
    logic               rsp_valid;
    logic [`WORD_W-1:0] rsp_data;
    t_fabric_addr       rsp_target;

    // ====================
    // Pack / unpack
    // ====================
    assign in_trans.address      = in_address;
    assign in_trans.data         = in_data;
    assign in_trans.opcode       = t_opcode'(in_opcode);
    assign in_trans.requestor_id = in_requestor_id;

    assign out_address      = out_trans.address;
    assign out_data         = out_trans.data;
    assign out_opcode       = out_trans.opcode;
    assign out_requestor_id = out_trans.requestor_id;

    mem_req_if req_if ();

    fabric_req_decode u_decode (
        .in_valid (in_valid),
        .in_trans (in_trans),
        .req      (req_if.dec)
    );

    tile_mem_array u_array (
        .clock        (clock),
        .rst_n        (rst_n),
        .pc           (pc),
        .instruction  (instruction),
        .dmem_address (dmem_address),
        .dmem_wr_data (dmem_wr_data),
        .dmem_byte_en (dmem_byte_en),
        .dmem_wr_en   (dmem_wr_en),
        .dmem_rd_data (dmem_rd_data),
        .req          (req_if.exe),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .rsp_target   (rsp_target)
    );

    rd_rsp_queue u_rsp_queue (
        .clock         (clock),
        .rst_n         (rst_n),
        .local_tile_id (local_tile_id),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_target    (rsp_target),
        .out_stall     (out_stall),
        .out_valid     (out_valid),
        .out_trans     (out_trans),
        .rsp_full      (rsp_full)
    );

endmodule

`default_nettype wire

// File: verif/tile_mem_tb.sv
/* Testbench for the tile memory: clock, reset, core and fabric stimulus,
   reference memory model, expected response queue and checking assertions */
`default_nettype none
`timescale 1ns/1ps

`include "tile_mem_macros.svh"

module tile_mem_tb;
    import tile_mem_pkg::*;

    // ====================
    // DUT signals
    // ====================
    logic                  clock = 1'b0;
    logic                  rst_n = 1'b0;
    logic [`TILE_ID_W-1:0] local_tile_id = 8'h3c;
    logic [31:0]           pc = '0;
    logic [`WORD_W-1:0]    instruction;
    logic [31:0]           dmem_address = '0;
    logic [`WORD_W-1:0]    dmem_wr_data = '0;
    logic [3:0]            dmem_byte_en = '0;
    logic                  dmem_wr_en = 1'b0;
    logic [`WORD_W-1:0]    dmem_rd_data;
    logic                  in_valid = 1'b0;
    logic [31:0]           in_address = '0;
    logic [`WORD_W-1:0]    in_data = '0;
    logic [1:0]            in_opcode = '0;
    logic [`TILE_ID_W-1:0] in_requestor_id = '0;
    logic                  out_valid;
    logic [31:0]           out_address;
    logic [`WORD_W-1:0]    out_data;
    logic [1:0]            out_opcode;
    logic [`TILE_ID_W-1:0] out_requestor_id;
    logic                  out_stall = 1'b0;
    logic                  rsp_full;

    // Reference model, expected responses
    logic [31:0] imem_model [2**`IMEM_ADDR_W];
    logic [31:0] dmem_model [2**`DMEM_ADDR_W];
    logic [31:0] exp_addr [64];             // Expected response queue
    logic [31:0] exp_data [64];
    int          exp_wr = 0;                // Push index
    int          exp_rd = 0;                // Pop index, one per out_valid
    logic [31:0] exp_word = '0;             // For instruction or dmem_rd_data
    logic        chk_instr = 1'b0;
    logic        chk_drd = 1'b0;
    logic        chk_full = 1'b0;
    logic        lat_mode = 1'b0;           // Lone reads, empty FIFO, no stall
    logic        seen_read = 1'b0;
    logic        rd_issue;
    logic [23:0] imem_offs [8];
    logic [23:0] dmem_offs [8];
    int          seed;

    initial begin
        forever #4 clock = ~clock;          // 8 ns period
    end

    tile_mem_top dut_i (.*);

    assign rd_issue = in_valid && (in_opcode == RD);

    always @(posedge clock) begin
        if (rst_n && out_valid) begin
            exp_rd <= exp_rd + 1;           // Head consumed
        end
    end

    // ====================
    // Helpers
    // ====================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "tile_mem_tb stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, want));
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;                                 // Drive just after the edge
    endtask

    function automatic int imem_idx(input logic [23:0] offset);
        return int'(offset[`IMEM_ADDR_W+`WORD_LSB-1:`WORD_LSB]);
    endfunction

    function automatic int dmem_idx(input logic [23:0] offset);
        return int'(offset[`DMEM_ADDR_W+`WORD_LSB-1:`WORD_LSB]);
    endfunction

    // One fabric strobe, model and expected queue updated alongside
    task automatic fabric_req(input logic [1:0] op, input logic [7:0] region,
                              input logic [23:0] offset, input logic [31:0] data);
        in_valid        = 1'b1;
        in_opcode       = op;
        in_address      = {region, offset};
        in_data         = data;
        in_requestor_id = 8'($random(seed));
        if (op == WR && region == `IMEM_REGION) begin
            imem_model[imem_idx(offset)] = data;
        end else if (op == WR && region == `DMEM_REGION) begin
            dmem_model[dmem_idx(offset)] = data;
        end
        if (op == RD) begin
            exp_addr[exp_wr] = {in_requestor_id, offset};   // Requestor becomes target
            exp_data[exp_wr] = (region == `IMEM_REGION) ? imem_model[imem_idx(offset)] :
                               (region == `DMEM_REGION) ? dmem_model[dmem_idx(offset)] : '0;
            exp_wr++;
            seen_read = 1'b1;
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic core_write(input logic [23:0] offset, input logic [31:0] data,
                              input logic [3:0] be);
        dmem_address = {8'h00, offset};
        dmem_wr_data = data;
        dmem_byte_en = be;
        dmem_wr_en   = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                dmem_model[dmem_idx(offset)][8*i +: 8] = data[8*i +: 8];    // Byte merge
            end
        end
        next_cycle();
        dmem_wr_en = 1'b0;
    endtask

    // Address sampled at edge k, word compared at edge k+1
    task automatic read_and_check(input bit from_dmem, input logic [23:0] offset);
        if (from_dmem) begin
            dmem_address = {8'h00, offset};
        end else begin
            pc = {8'h00, offset};
        end
        next_cycle();
        exp_word  = from_dmem ? dmem_model[dmem_idx(offset)] : imem_model[imem_idx(offset)];
        chk_instr = !from_dmem;
        chk_drd   = from_dmem;
        next_cycle();
        chk_instr = 1'b0;
        chk_drd   = 1'b0;
    endtask

    // Poll for rsp_full, or for every expected response
    task automatic wait_for(input bit full, input int limit);
        int n;
        n = 0;
        while (full ? !rsp_full : (exp_rd != exp_wr)) begin
            if (n == limit) begin
                abort_run(full ? "Timeout waiting for rsp_full to rise"
                               : "Timeout waiting for read responses");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // ====================
    // Checks
    // ====================
    a_idle: assert property (@(posedge clock) disable iff (!rst_n)
        !seen_read |-> !out_valid && !rsp_full)
        else report_mismatch("out_valid,rsp_full", {$sampled(out_valid), $sampled(rsp_full)}, 0);
    a_instr: assert property (@(posedge clock) disable iff (!rst_n)
        chk_instr |-> instruction == exp_word)
        else report_mismatch("instruction", $sampled(instruction), $sampled(exp_word));
    a_dmem_rd: assert property (@(posedge clock) disable iff (!rst_n)
        chk_drd |-> dmem_rd_data == exp_word)
        else report_mismatch("dmem_rd_data", $sampled(dmem_rd_data), $sampled(exp_word));
    a_rsp_pending: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> exp_rd < exp_wr)
        else abort_run("Response arrived with no fabric read outstanding");
    a_rsp_opcode: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> out_opcode == RD_RSP)
        else report_mismatch("out_opcode", $sampled(out_opcode), RD_RSP);
    a_rsp_requestor: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> out_requestor_id == local_tile_id)
        else report_mismatch("out_requestor_id", $sampled(out_requestor_id), local_tile_id);
    a_rsp_addr: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> out_address == exp_addr[exp_rd])
        else report_mismatch("out_address", $sampled(out_address), exp_addr[$sampled(exp_rd)]);
    a_rsp_data: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> out_data == exp_data[exp_rd])
        else report_mismatch("out_data", $sampled(out_data), exp_data[$sampled(exp_rd)]);
    a_stall: assert property (@(posedge clock) disable iff (!rst_n)
        out_stall |-> !out_valid)
        else report_mismatch("out_valid", $sampled(out_valid), 0);
    a_full: assert property (@(posedge clock) disable iff (!rst_n)
        chk_full |-> rsp_full)
        else report_mismatch("rsp_full", $sampled(rsp_full), 1);
    a_lat_early: assert property (@(posedge clock) disable iff (!rst_n)
        lat_mode && $past(rd_issue) |-> !out_valid)
        else abort_run("out_valid one cycle after a lone read, expected two");
    a_lat_exact: assert property (@(posedge clock) disable iff (!rst_n)
        lat_mode && $past(rd_issue, 2) |-> out_valid)
        else abort_run("out_valid missing two cycles after a lone read");

    // ====================
    // Stimulus
    // ====================
    initial begin
        seed = 32'hfcf75270;
        repeat (10) @(posedge clock);
        #1;
        rst_n = 1'b1;
        repeat (4) next_cycle();            // Quiet outputs after reset

        // Fabric fills IMEM, core fetches it back
        for (int i = 0; i < 8; i++) begin
            imem_offs[i] = 24'($random(seed));
            fabric_req(WR, `IMEM_REGION, imem_offs[i], $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            read_and_check(1'b0, imem_offs[i]);
        end

        // DMEM full words, then core byte writes seen by core and fabric
        for (int i = 0; i < 8; i++) begin
            dmem_offs[i] = 24'($random(seed));
            fabric_req(WR, `DMEM_REGION, dmem_offs[i], $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            core_write(dmem_offs[i], $random(seed), 4'($random(seed)));
            read_and_check(1'b1, dmem_offs[i]);
            fabric_req(RD, `DMEM_REGION, dmem_offs[i], '0);
        end
        wait_for(1'b0, 20);

        // Unmapped region, writes dropped and reads answer zero
        fabric_req(WR, 8'h07, dmem_offs[0], $random(seed));
        fabric_req(WR, 8'h00, imem_offs[0], $random(seed));
        fabric_req(RD, 8'h07, 24'($random(seed)), '0);
        fabric_req(RD, `DMEM_REGION, dmem_offs[0], '0);
        fabric_req(RD, `IMEM_REGION, imem_offs[0], '0);
        wait_for(1'b0, 20);
        read_and_check(1'b0, imem_offs[0]);

        // Stalled fabric fills the FIFO, release drains in order
        out_stall = 1'b1;
        for (int i = 0; i < 4; i++) begin
            fabric_req(RD, `DMEM_REGION, dmem_offs[i+1], '0);
        end
        wait_for(1'b1, 10);
        chk_full = 1'b1;
        repeat (3) next_cycle();
        chk_full  = 1'b0;
        out_stall = 1'b0;
        wait_for(1'b0, 20);

        // Lone reads, two cycle latency
        lat_mode = 1'b1;
        for (int i = 0; i < 4; i++) begin
            fabric_req(RD, `IMEM_REGION, imem_offs[i+2], '0);
            wait_for(1'b0, 10);
            next_cycle();
        end
        lat_mode = 1'b0;

        wait_for(1'b0, 20);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/tile_mem_pkg.sv
src/mem_req_if.sv
src/fabric_req_decode.sv
src/dual_port_ram.sv
src/tile_mem_array.sv
src/rd_rsp_queue.sv
src/tile_mem_top.sv
verif/tile_mem_tb.sv

// File: Makefile
# Verilator build and run, lint and clean for the tile memory
TOP = tile_mem_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f src/*.sv src/*.svh verif/*.sv
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
